/* logic/backend_pkg.sv */
// widths, value typedefs, alu function and unit state encodings
// sizing constants shared by the out-of-order backend
package backend_pkg;

	////////////////////////////////////////
	// sizing
	////////////////////////////////////////
	localparam int WORD_W       = 64;                    // operand and result width
	localparam int PRF_SIZE     = 64;                    // number of physical tags
	localparam int TAG_W        = $clog2(PRF_SIZE);      // 6 bit tag
	localparam int RS_DEPTH     = 8;                     // station entries
	localparam int RS_IDX_W     = $clog2(RS_DEPTH);      // entry index width
	localparam int MULT_STAGES  = 4;                     // multiplier pipe depth
	localparam int MULT_CHUNK_W = WORD_W / MULT_STAGES;  // opb bits folded in per stage
	localparam int NUM_FU       = 3;                     // 0 alu0, 1 alu1, 2 mult
	localparam int FU_IDX_W     = $clog2(NUM_FU);        // requester index width
	localparam int SHAMT_W      = 6;                     // shift amount taken from opb

	////////////////////////////////////////
	// value types
	////////////////////////////////////////
	typedef logic [WORD_W-1:0]   word_t;     // operand or result value
	typedef logic [TAG_W-1:0]    prf_tag_t;  // physical register tag
	typedef logic [RS_IDX_W-1:0] rs_idx_t;   // station slot
	typedef logic [RS_IDX_W:0]   rs_age_t;   // one spare bit so ages saturate late
	typedef logic [FU_IDX_W-1:0] fu_idx_t;   // bus requester number

	////////////////////////////////////////
	// encodings
	////////////////////////////////////////
	typedef enum logic [2:0] {
		ALU_ADD,   // a + b
		ALU_SUB,   // a - b
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,   // a << b[5:0]
		ALU_MULQ   // low half of a * b, multiplier only
	} alu_func_t;

	typedef enum logic {
		FU_IDLE,   // result register empty
		FU_HOLD    // result waiting for the cdb
	} fu_state_t;

endpackage

/* logic/cdb_arbiter.sv */
`timescale 1ns/1ps
// round-robin arbiter over the functional units and the registered cdb driver
module cdb_arbiter import backend_pkg::*; (
	input  logic                    clock,
	input  logic                    reset,
	input  logic     [NUM_FU-1:0]   fu_req,
	input  prf_tag_t [NUM_FU-1:0]   fu_tag,
	input  word_t    [NUM_FU-1:0]   fu_value,
	output logic     [NUM_FU-1:0]   fu_grant,
	output logic                    cdb_valid,
	output prf_tag_t                cdb_tag,
	output word_t                   cdb_value
);
	fu_idx_t rr_ptr;      // first requester looked at this cycle
	fu_idx_t grant_idx;
	logic    grant_any;

	////////////////////////////////////////
	// grant search from the pointer
	////////////////////////////////////////
	always_comb begin
		int unsigned cand;
		grant_any = 1'b0;
		grant_idx = '0;
		fu_grant  = '0;
		for (int i = 0; i < NUM_FU; i++) begin
			cand = (int'(rr_ptr) + i) % NUM_FU;  // wrap, NUM_FU need not be a power of two
			if (!grant_any && fu_req[cand]) begin
				grant_any = 1'b1;
				grant_idx = fu_idx_t'(cand);
			end
		end
		if (grant_any)
			fu_grant[grant_idx] = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rr_ptr    <= '0;
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= grant_any;   // one broadcast per grant
			if (grant_any)
				rr_ptr <= (grant_idx == fu_idx_t'(NUM_FU - 1)) ? '0 : grant_idx + 1'b1;
		end
	end

	// bus payload
	always_ff @(posedge clock) begin
		if (grant_any) begin
			cdb_tag   <= fu_tag[grant_idx];
			cdb_value <= fu_value[grant_idx];
		end
	end

endmodule

/* logic/int_alu_unit.sv */
`timescale 1ns/1ps
// single-cycle integer alu, result held until the cdb grants it
module int_alu_unit import backend_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      issue_valid,
	output logic      issue_ready,
	input  alu_func_t issue_func,
	input  word_t     issue_opa,
	input  word_t     issue_opb,
	input  prf_tag_t  issue_dest,
	output logic      req,
	input  logic      grant,
	output prf_tag_t  res_tag,
	output word_t     res_value
);
	fu_state_t state, state_next;
	logic      take;     // op accepted this edge
	word_t     alu_out;

	function automatic word_t alu_eval(alu_func_t func, word_t a, word_t b);
		case (func)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[SHAMT_W-1:0];
			default: return '0;   // mulq never issues here
		endcase
	endfunction

	assign alu_out     = alu_eval(issue_func, issue_opa, issue_opb);
	assign issue_ready = (state == FU_IDLE) | grant;  // grant frees the register this edge
	assign take        = issue_valid & issue_ready;
	assign req         = (state == FU_HOLD);

	always_comb begin
		state_next = state;
		case (state)
			FU_IDLE: begin
				if (take)
					state_next = FU_HOLD;
			end
			FU_HOLD: begin
				if (grant)
					state_next = take ? FU_HOLD : FU_IDLE;  // back to back
			end
			default: state_next = FU_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= FU_IDLE;
		else
			state <= state_next;
	end

	// result register
	always_ff @(posedge clock) begin
		if (take) begin
			res_tag   <= issue_dest;
			res_value <= alu_out;
		end
	end

endmodule

/* logic/mult_unit.sv */
`timescale 1ns/1ps
// pipelined 64 bit multiplier, one opb chunk per stage, freezes while its result waits
module mult_unit import backend_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     issue_valid,
	output logic     issue_ready,
	input  word_t    issue_opa,
	input  word_t    issue_opb,
	input  prf_tag_t issue_dest,
	output logic     req,
	input  logic     grant,
	output prf_tag_t res_tag,
	output word_t    res_value
);
	localparam int LAST = MULT_STAGES - 1;

	logic [MULT_STAGES-1:0] stage_valid;
	prf_tag_t               stage_tag [MULT_STAGES];
	word_t                  stage_acc [MULT_STAGES];  // running partial product
	word_t                  stage_opa [MULT_STAGES-1];  // operands ride along until the last chunk
	word_t                  stage_opb [MULT_STAGES-1];
	logic                   stall;

	// a times one chunk of b, shifted into place, low word only
	function automatic word_t chunk_product(word_t a, word_t b, int unsigned idx);
		logic [MULT_CHUNK_W-1:0] chunk;
		chunk = b[idx*MULT_CHUNK_W +: MULT_CHUNK_W];
		return word_t'(a * chunk) << (idx * MULT_CHUNK_W);
	endfunction

	assign stall       = stage_valid[LAST] & ~grant;  // result not taken, hold every stage
	assign issue_ready = ~stall;
	assign req         = stage_valid[LAST];
	assign res_tag     = stage_tag[LAST];
	assign res_value   = stage_acc[LAST];

	////////////////////////////////////////
	// valid chain
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset)
			stage_valid <= '0;
		else if (!stall)
			stage_valid <= {stage_valid[MULT_STAGES-2:0], issue_valid};
	end

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!stall) begin
			stage_tag[0] <= issue_dest;
			stage_acc[0] <= chunk_product(issue_opa, issue_opb, 0);  // chunk 0 on entry
			stage_opa[0] <= issue_opa;
			stage_opb[0] <= issue_opb;
			for (int s = 1; s < MULT_STAGES; s++) begin
				stage_tag[s] <= stage_tag[s-1];
				stage_acc[s] <= stage_acc[s-1] + chunk_product(stage_opa[s-1], stage_opb[s-1], s);
			end
			for (int s = 1; s < MULT_STAGES - 1; s++) begin
				stage_opa[s] <= stage_opa[s-1];
				stage_opb[s] <= stage_opb[s-1];
			end
		end
	end

endmodule

/* logic/ooo_backend.sv */
`timescale 1ns/1ps
// out-of-order backend top, station, two alus, multiplier and cdb arbiter
module ooo_backend import backend_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      dispatch_valid,
	output logic      dispatch_ready,
	input  alu_func_t dispatch_func,
	input  prf_tag_t  dispatch_dest,
	input  word_t     dispatch_opa,
	input  logic      dispatch_opa_ready,
	input  prf_tag_t  dispatch_opa_tag,
	input  word_t     dispatch_opb,
	input  logic      dispatch_opb_ready,
	input  prf_tag_t  dispatch_opb_tag,
	output logic      cdb_valid,
	output prf_tag_t  cdb_tag,
	output word_t     cdb_value
);
	// station to units
	logic      alu0_issue_valid, alu0_issue_ready;
	alu_func_t alu0_issue_func;
	word_t     alu0_issue_opa, alu0_issue_opb;
	prf_tag_t  alu0_issue_dest;
	logic      alu1_issue_valid, alu1_issue_ready;
	alu_func_t alu1_issue_func;
	word_t     alu1_issue_opa, alu1_issue_opb;
	prf_tag_t  alu1_issue_dest;
	logic      mult_issue_valid, mult_issue_ready;
	word_t     mult_issue_opa, mult_issue_opb;
	prf_tag_t  mult_issue_dest;

	// units to arbiter, index 0 alu0, 1 alu1, 2 mult
	logic     [NUM_FU-1:0] fu_req, fu_grant;
	prf_tag_t [NUM_FU-1:0] fu_tag;
	word_t    [NUM_FU-1:0] fu_value;

	////////////////////////////////////////
	// issue side
	////////////////////////////////////////
	reservation_station rs (.*);  // cdb loops back here for wakeup

	int_alu_unit alu0 (
		.clock(clock), .reset(reset),
		.issue_valid(alu0_issue_valid), .issue_ready(alu0_issue_ready),
		.issue_func(alu0_issue_func), .issue_opa(alu0_issue_opa),
		.issue_opb(alu0_issue_opb), .issue_dest(alu0_issue_dest),
		.req(fu_req[0]), .grant(fu_grant[0]), .res_tag(fu_tag[0]), .res_value(fu_value[0])
	);

	int_alu_unit alu1 (
		.clock(clock), .reset(reset),
		.issue_valid(alu1_issue_valid), .issue_ready(alu1_issue_ready),
		.issue_func(alu1_issue_func), .issue_opa(alu1_issue_opa),
		.issue_opb(alu1_issue_opb), .issue_dest(alu1_issue_dest),
		.req(fu_req[1]), .grant(fu_grant[1]), .res_tag(fu_tag[1]), .res_value(fu_value[1])
	);

	mult_unit mult (
		.clock(clock), .reset(reset),
		.issue_valid(mult_issue_valid), .issue_ready(mult_issue_ready),
		.issue_opa(mult_issue_opa), .issue_opb(mult_issue_opb), .issue_dest(mult_issue_dest),
		.req(fu_req[2]), .grant(fu_grant[2]), .res_tag(fu_tag[2]), .res_value(fu_value[2])
	);

	////////////////////////////////////////
	// broadcast side
	////////////////////////////////////////
	cdb_arbiter arb (
		.clock(clock), .reset(reset),
		.fu_req(fu_req), .fu_tag(fu_tag), .fu_value(fu_value), .fu_grant(fu_grant),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
	);

endmodule

/* logic/reservation_station.sv */
`timescale 1ns/1ps
// reservation station with cdb wakeup, oldest-ready select and issue to alus and multiplier
module reservation_station import backend_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	// dispatch
	input  logic      dispatch_valid,
	output logic      dispatch_ready,
	input  alu_func_t dispatch_func,
	input  prf_tag_t  dispatch_dest,
	input  word_t     dispatch_opa,
	input  logic      dispatch_opa_ready,
	input  prf_tag_t  dispatch_opa_tag,
	input  word_t     dispatch_opb,
	input  logic      dispatch_opb_ready,
	input  prf_tag_t  dispatch_opb_tag,
	// alu 0 issue
	output logic      alu0_issue_valid,
	input  logic      alu0_issue_ready,
	output alu_func_t alu0_issue_func,
	output word_t     alu0_issue_opa,
	output word_t     alu0_issue_opb,
	output prf_tag_t  alu0_issue_dest,
	// alu 1 issue
	output logic      alu1_issue_valid,
	input  logic      alu1_issue_ready,
	output alu_func_t alu1_issue_func,
	output word_t     alu1_issue_opa,
	output word_t     alu1_issue_opb,
	output prf_tag_t  alu1_issue_dest,
	// multiplier issue
	output logic      mult_issue_valid,
	input  logic      mult_issue_ready,
	output word_t     mult_issue_opa,
	output word_t     mult_issue_opb,
	output prf_tag_t  mult_issue_dest,
	// common data bus snoop
	input  logic      cdb_valid,
	input  prf_tag_t  cdb_tag,
	input  word_t     cdb_value
);
	logic      [RS_DEPTH-1:0] ent_valid;                  // slot holds an op
	rs_age_t   [RS_DEPTH-1:0] ent_age;                    // cycles spent waiting, saturating
	alu_func_t                ent_func    [RS_DEPTH];
	prf_tag_t                 ent_dest    [RS_DEPTH];
	word_t                    ent_opa     [RS_DEPTH];
	word_t                    ent_opb     [RS_DEPTH];
	prf_tag_t                 ent_opa_tag [RS_DEPTH];
	prf_tag_t                 ent_opb_tag [RS_DEPTH];
	logic      [RS_DEPTH-1:0] ent_opa_rdy;
	logic      [RS_DEPTH-1:0] ent_opb_rdy;
	logic      [RS_DEPTH-1:0] alu_cand, mul_cand;         // fully ready ops per class
	rs_idx_t                  alloc_idx, alu_sel, mul_sel;
	logic                     take, opa_hit, opb_hit;
	logic                     alu_fire, mul_fire;

	// oldest candidate wins, lowest slot on a tie
	function automatic rs_idx_t pick_oldest(logic [RS_DEPTH-1:0] cand,
	                                        rs_age_t [RS_DEPTH-1:0] age);
		rs_idx_t best;
		rs_age_t best_age;
		logic    found;
		best     = '0;
		best_age = '0;
		found    = 1'b0;
		for (int e = 0; e < RS_DEPTH; e++) begin
			if (cand[e] && (!found || age[e] > best_age)) begin
				best     = rs_idx_t'(e);
				best_age = age[e];
				found    = 1'b1;
			end
		end
		return best;
	endfunction

	////////////////////////////////////////
	// allocation and dispatch bypass
	////////////////////////////////////////
	always_comb begin
		alloc_idx = '0;
		for (int e = RS_DEPTH - 1; e >= 0; e--) begin
			if (!ent_valid[e])
				alloc_idx = rs_idx_t'(e);   // lowest free slot
		end
	end

	assign dispatch_ready = ~&ent_valid;                     // any slot free
	assign take           = dispatch_valid & dispatch_ready;
	assign opa_hit = !dispatch_opa_ready && cdb_valid && cdb_tag == dispatch_opa_tag;
	assign opb_hit = !dispatch_opb_ready && cdb_valid && cdb_tag == dispatch_opb_tag;

	////////////////////////////////////////
	// select and issue
	////////////////////////////////////////
	always_comb begin
		for (int e = 0; e < RS_DEPTH; e++) begin
			alu_cand[e] = ent_valid[e] && ent_opa_rdy[e] && ent_opb_rdy[e] && ent_func[e] != ALU_MULQ;
			mul_cand[e] = ent_valid[e] && ent_opa_rdy[e] && ent_opb_rdy[e] && ent_func[e] == ALU_MULQ;
		end
	end

	assign alu_sel = pick_oldest(alu_cand, ent_age);
	assign mul_sel = pick_oldest(mul_cand, ent_age);

	assign alu0_issue_valid = |alu_cand & alu0_issue_ready;                     // alu 0 first
	assign alu1_issue_valid = |alu_cand & ~alu0_issue_ready & alu1_issue_ready; // fallback
	assign alu0_issue_func  = ent_func[alu_sel];
	assign alu0_issue_opa   = ent_opa[alu_sel];
	assign alu0_issue_opb   = ent_opb[alu_sel];
	assign alu0_issue_dest  = ent_dest[alu_sel];
	assign alu1_issue_func  = ent_func[alu_sel];  // same op, steered to whichever alu is free
	assign alu1_issue_opa   = ent_opa[alu_sel];
	assign alu1_issue_opb   = ent_opb[alu_sel];
	assign alu1_issue_dest  = ent_dest[alu_sel];
	assign mult_issue_valid = |mul_cand;
	assign mult_issue_opa   = ent_opa[mul_sel];
	assign mult_issue_opb   = ent_opb[mul_sel];
	assign mult_issue_dest  = ent_dest[mul_sel];

	assign alu_fire = (alu0_issue_valid & alu0_issue_ready) | (alu1_issue_valid & alu1_issue_ready);
	assign mul_fire = mult_issue_valid & mult_issue_ready;

	////////////////////////////////////////
	// entry state
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			ent_valid <= '0;
			ent_age   <= '0;
		end else begin
			for (int e = 0; e < RS_DEPTH; e++) begin
				if ((alu_fire && alu_sel == rs_idx_t'(e)) || (mul_fire && mul_sel == rs_idx_t'(e)))
					ent_valid[e] <= 1'b0;           // freed on issue
				if (ent_valid[e] && ent_age[e] != '1)
					ent_age[e] <= ent_age[e] + 1'b1;
			end
			if (take) begin
				ent_valid[alloc_idx] <= 1'b1;
				ent_age[alloc_idx]   <= '0;         // youngest
			end
		end
	end

	// operand payload, wakeup from the cdb
	always_ff @(posedge clock) begin
		for (int e = 0; e < RS_DEPTH; e++) begin
			if (cdb_valid && ent_valid[e] && !ent_opa_rdy[e] && ent_opa_tag[e] == cdb_tag) begin
				ent_opa[e]     <= cdb_value;
				ent_opa_rdy[e] <= 1'b1;
			end
			if (cdb_valid && ent_valid[e] && !ent_opb_rdy[e] && ent_opb_tag[e] == cdb_tag) begin
				ent_opb[e]     <= cdb_value;
				ent_opb_rdy[e] <= 1'b1;
			end
		end
		if (take) begin
			ent_func[alloc_idx]    <= dispatch_func;
			ent_dest[alloc_idx]    <= dispatch_dest;
			ent_opa[alloc_idx]     <= opa_hit ? cdb_value : dispatch_opa;  // catch same-cycle broadcast
			ent_opb[alloc_idx]     <= opb_hit ? cdb_value : dispatch_opb;
			ent_opa_rdy[alloc_idx] <= dispatch_opa_ready | opa_hit;
			ent_opb_rdy[alloc_idx] <= dispatch_opb_ready | opb_hit;
			ent_opa_tag[alloc_idx] <= dispatch_opa_tag;
			ent_opb_tag[alloc_idx] <= dispatch_opb_tag;
		end
	end

endmodule

/* project.f */
+incdir+include
logic/backend_pkg.sv
logic/reservation_station.sv
logic/int_alu_unit.sv
logic/mult_unit.sv
logic/cdb_arbiter.sv
logic/ooo_backend.sv
testbench/backend_checker.sv
testbench/backend_tb.sv

/* testbench/backend_checker.sv */
`timescale 1ns/1ps
// bus arbitration properties bound into cdb_arbiter
module backend_checker import backend_pkg::*; (
	input logic              clock,
	input logic              reset,
	input logic [NUM_FU-1:0] fu_req,
	input logic [NUM_FU-1:0] fu_grant,
	input logic              cdb_valid
);
	int fail_count = 0;   // failed assertion count

	// one owner of the bus at most
	assert property (@(posedge clock) disable iff (reset) $onehot0(fu_grant))
		else begin
			$error("more than one unit granted");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (reset) (fu_grant & ~fu_req) == '0)
		else begin
			$error("grant to a unit with no request");
			fail_count++;
		end

	assert property (@(posedge clock) disable iff (reset) (|fu_grant) |=> cdb_valid)
		else begin
			$error("grant not followed by a broadcast");
			fail_count++;
		end

	for (genvar i = 0; i < NUM_FU; i++) begin : g_hold
		assert property (@(posedge clock) disable iff (reset)
		                 fu_req[i] && !fu_grant[i] |=> fu_req[i])
			else begin
				$error("unit %0d dropped its request before a grant", i);
				fail_count++;
			end
	end

endmodule

bind cdb_arbiter backend_checker arb_chk (
	.clock(clock), .reset(reset), .fu_req(fu_req), .fu_grant(fu_grant), .cdb_valid(cdb_valid)
);

/* include/backend_tb_tasks.svh */
// compare tasks, test bookkeeping and the directed tests of the backend testbench
`ifndef BACKEND_TB_TASKS_SVH
`define BACKEND_TB_TASKS_SVH

////////////////////////////////////////
// compare tasks
////////////////////////////////////////
task automatic compare_word(input string what, input word_t expected, input word_t actual);
	if (actual !== expected) begin
		$display("FAILED %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
		errors++;
	end
endtask

task automatic compare_tag(input string what, input prf_tag_t expected, input prf_tag_t actual);
	if (actual !== expected) begin
		$display("FAILED %s, %s: expected %0d, actual %0d", cur_test, what, expected, actual);
		errors++;
	end
endtask

task automatic compare_bit(input string what, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("FAILED %s, %s: expected %b, actual %b", cur_test, what, expected, actual);
		errors++;
	end
endtask

task automatic start_test(input string name);
	cur_test      = name;
	test_err_base = errors;   // errors seen before this test
endtask

task automatic finish_test();
	if (errors == test_err_base) begin
		tests_ok++;
		$display("test %s: ok", cur_test);
	end else begin
		tests_bad++;
		$display("test %s: %0d errors", cur_test, errors - test_err_base);
	end
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////
task automatic check_reset_state();
	start_test("reset");
	@(negedge clock);
	compare_bit("cdb_valid", 1'b0, cdb_valid);           // bus quiet
	compare_bit("dispatch_ready", 1'b1, dispatch_ready); // empty station
	@(posedge clock);
	#1;
	finish_test();
endtask

task automatic every_alu_function();
	prf_tag_t tag;
	start_test("alu functions");
	for (int f = 0; f <= int'(ALU_MULQ); f++)
		dispatch_op(alu_func_t'(f), 1'b0, '0, 1'b0, '0, tag);  // independent ops with random operands
	drain();
	finish_test();
endtask

task automatic dependency_chain();
	prf_tag_t chain [$];
	prf_tag_t tag;
	start_test("dependency chain");
	bcast_order.delete();
	dispatch_op(ALU_ADD, 1'b0, '0, 1'b0, '0, tag);
	chain.push_back(tag);
	for (int i = 1; i < 6; i++) begin
		dispatch_op((i == 3) ? ALU_MULQ : alu_func_t'(i), 1'b1, chain[i-1], 1'b0, '0, tag);
		chain.push_back(tag);                                  // opa waits on the previous op
	end
	drain();
	foreach (chain[i])
		compare_tag($sformatf("broadcast %0d", i), chain[i], bcast_order[i]);  // in order
	finish_test();
endtask

task automatic mixed_traffic();
	prf_tag_t  tag, prev;
	alu_func_t func;
	start_test("mixed traffic");
	prev = '0;
	for (int i = 0; i < 12; i++) begin
		func = (i % 3 == 0) ? ALU_MULQ : alu_func_t'(i % 5);   // every third op multiplies
		dispatch_op(func, i % 4 == 3, prev, 1'b0, '0, tag);    // some wait on the op before
		prev = tag;
	end
	drain();                                                    // returns once no tag is missing
	finish_test();
endtask

task automatic full_station();
	prf_tag_t first_mul, gate_mul, tag;
	start_test("full station");
	saw_full = 1'b0;
	dispatch_op(ALU_MULQ, 1'b0, '0, 1'b0, '0, first_mul);
	dispatch_op(ALU_MULQ, 1'b1, first_mul, 1'b0, '0, gate_mul);  // the multiply all others wait on
	for (int i = 0; i < RS_DEPTH + 2; i++)
		dispatch_op(alu_func_t'(i % 7), 1'b0, '0, 1'b1, gate_mul, tag);
	drain();
	compare_bit("dispatch_ready dropped", 1'b1, saw_full);
	finish_test();
endtask

`endif

/* testbench/backend_tb.sv */
`timescale 1ns/1ps
// testbench for the out-of-order backend
// clock, reset, dut, scoreboard by tag, bus monitor, watchdog and final report
module backend_tb import backend_pkg::*; ;
	localparam int TOTAL_OPS      = 37;   // ops dispatched over all tests
	localparam int WATCHDOG_TICKS = TOTAL_OPS * (MULT_STAGES + NUM_FU + RS_DEPTH) + 200;

	logic      clock, reset;
	logic      dispatch_valid, dispatch_ready;
	alu_func_t dispatch_func;
	prf_tag_t  dispatch_dest, dispatch_opa_tag, dispatch_opb_tag;
	word_t     dispatch_opa, dispatch_opb;
	logic      dispatch_opa_ready, dispatch_opb_ready;
	logic      cdb_valid;
	prf_tag_t  cdb_tag;
	word_t     cdb_value;

	word_t               exp_value [PRF_SIZE];  // expected result per tag
	logic [PRF_SIZE-1:0] in_flight;             // dispatched and not yet broadcast
	prf_tag_t            bcast_order [$];
	prf_tag_t            next_tag;
	logic                saw_full;              // dispatch_ready seen low
	int                  errors, tests_ok, tests_bad, test_err_base;
	string               cur_test;

	ooo_backend dut (.*);

	`include "backend_tb_tasks.svh"

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic word_t expected_result(alu_func_t func, word_t a, word_t b);
		case (func)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[5:0];
			default: return a * b;   // low 64 bits of the product
		endcase
	endfunction

	function automatic word_t random_word();
		return {$urandom, $urandom};
	endfunction

	////////////////////////////////////////
	// dispatch and drain
	////////////////////////////////////////
	task automatic dispatch_op(input alu_func_t func, input logic a_dep, input prf_tag_t a_src,
	                           input logic b_dep, input prf_tag_t b_src, output prf_tag_t dest);
		word_t a, b;
		while (!dispatch_ready) begin
			saw_full = 1'b1;
			@(posedge clock);
			#1;
		end
		a = random_word();
		b = random_word();
		dispatch_opa_ready = !(a_dep && in_flight[a_src]);   // value known once its broadcast was seen
		dispatch_opb_ready = !(b_dep && in_flight[b_src]);
		if (a_dep)
			a = exp_value[a_src];
		if (b_dep)
			b = exp_value[b_src];
		dest = next_tag;
		next_tag++;
		exp_value[dest] = expected_result(func, a, b);
		in_flight[dest] = 1'b1;
		dispatch_valid   = 1'b1;
		dispatch_func    = func;
		dispatch_dest    = dest;
		dispatch_opa     = dispatch_opa_ready ? a : ~a;   // junk while the tag is pending
		dispatch_opb     = dispatch_opb_ready ? b : ~b;
		dispatch_opa_tag = a_src;
		dispatch_opb_tag = b_src;
		@(posedge clock);                                 // accepted since ready was high
		#1;
		dispatch_valid = 1'b0;
	endtask

	task automatic drain();
		while (in_flight != '0) begin
			@(posedge clock);
			#1;
		end
	endtask

	// bus monitor samples the cdb at the falling edge where it is stable
	always @(negedge clock) begin
		if (!reset && cdb_valid) begin
			if (!in_flight[cdb_tag]) begin
				$display("error in %s: tag %0d was broadcast with no op waiting for it",
				         cur_test, cdb_tag);
				errors++;
			end else begin
				compare_word($sformatf("tag %0d", cdb_tag), exp_value[cdb_tag], cdb_value);
				in_flight[cdb_tag] = 1'b0;
				bcast_order.push_back(cdb_tag);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_TICKS) @(posedge clock);
		$display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_TICKS);
		$display("TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////
	initial begin
		void'($urandom(32'h6e6c3fa0));
		errors             = 0;
		tests_ok           = 0;
		tests_bad          = 0;
		next_tag           = '0;
		in_flight          = '0;
		saw_full           = 1'b0;
		cur_test           = "reset";
		reset              = 1'b1;
		dispatch_valid     = 1'b0;
		dispatch_func      = ALU_ADD;
		dispatch_dest      = '0;
		dispatch_opa       = '0;
		dispatch_opa_ready = 1'b1;
		dispatch_opa_tag   = '0;
		dispatch_opb       = '0;
		dispatch_opb_ready = 1'b1;
		dispatch_opb_tag   = '0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		check_reset_state();
		every_alu_function();
		dependency_chain();
		mixed_traffic();
		full_station();
		if (dut.arb.arb_chk.fail_count != 0) begin
			$display("error: %0d bus arbitration assertions failed",
			         dut.arb.arb_chk.fail_count);
			errors += dut.arb.arb_chk.fail_count;
		end
		$display("summary: %0d tests ok, %0d tests with errors, %0d errors",
		         tests_ok, tests_bad, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
